// ==== src/alu_macros.svh ====
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

`define ALU_WORD_W  32
`define ALU_DWORD_W 64
`define ALUOP_W     8

`define MUL_LATENCY 3   // edges from accepting start to ready, at least 3
`define DIV_ITER    32  // one quotient bit per step

// single-cycle ops
`define ALUOP_NOP   8'h00
`define ALUOP_ADD   8'h01
`define ALUOP_ADDU  8'h02
`define ALUOP_SUB   8'h03
`define ALUOP_SUBU  8'h04
`define ALUOP_SLT   8'h05
`define ALUOP_SLTU  8'h06
`define ALUOP_AND   8'h07
`define ALUOP_OR    8'h08
`define ALUOP_NOR   8'h09
`define ALUOP_XOR   8'h0a
`define ALUOP_LUI   8'h0b
`define ALUOP_SLL   8'h0c
`define ALUOP_SRL   8'h0d
`define ALUOP_SRA   8'h0e
`define ALUOP_ROTR  8'h0f
`define ALUOP_CLO   8'h10
`define ALUOP_CLZ   8'h11
`define ALUOP_MOV   8'h12
`define ALUOP_MFHI  8'h13
`define ALUOP_MFLO  8'h14
`define ALUOP_MFC0  8'h15
`define ALUOP_MTHI  8'h16
`define ALUOP_MTLO  8'h17

// multi-cycle ops
`define ALUOP_MULT  8'h18
`define ALUOP_MULTU 8'h19
`define ALUOP_MADD  8'h1a
`define ALUOP_MSUB  8'h1b
`define ALUOP_MADDU 8'h1c
`define ALUOP_MSUBU 8'h1d
`define ALUOP_DIV   8'h1e
`define ALUOP_DIVU  8'h1f

`endif

// ==== src/alu_pkg.sv ====
`include "alu_macros.svh"

package alu_pkg;

    typedef logic [`ALU_WORD_W-1:0]          word_t;
    typedef logic [`ALU_DWORD_W-1:0]         dword_t;
    typedef logic [`ALUOP_W-1:0]             aluop_t;
    typedef logic [$clog2(`ALU_WORD_W)-1:0]  shamt_t;

    // op as presented to execute
    typedef struct packed {
        aluop_t aluop;
        word_t  a;
        word_t  b;
        word_t  cp0_data;
    } ex_op_t;

    // execute -> writeback
    typedef struct packed {
        word_t  y;
        logic   overflow;
        logic   hilo_wr;
        dword_t hilo_next;   // {hi, lo}
    } ex_result_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_t;

endpackage

// ==== src/alu_simple.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_simple (
    input  alu_pkg::ex_op_t op,
    input  alu_pkg::dword_t hilo,
    output alu_pkg::word_t  y,
    output logic            overflow,
    output logic            hilo_wr,
    output alu_pkg::dword_t hilo_next
);
    import alu_pkg::*;

    shamt_t sh;
    dword_t rot;

    // run of bits equal to val from the msb, 32 when all match
    function automatic word_t lead_count(word_t v, logic val);
        word_t cnt;
        logic  run;
        cnt = '0;
        run = 1'b1;
        for (int i = `ALU_WORD_W - 1; i >= 0; i--) begin
            if (run && v[i] == val)
                cnt = cnt + 1'b1;
            else
                run = 1'b0;
        end
        return cnt;
    endfunction

    assign sh  = op.a[$bits(shamt_t)-1:0];
    assign rot = {op.b, op.b} >> sh;

    always_comb begin
        y         = '0;
        overflow  = 1'b0;
        hilo_wr   = 1'b0;
        hilo_next = hilo;
        case (op.aluop)
            `ALUOP_ADD: begin
                y        = op.a + op.b;
                overflow = (op.a[31] == op.b[31]) && (y[31] != op.a[31]);
            end
            `ALUOP_ADDU: y = op.a + op.b;
            `ALUOP_SUB: begin
                y        = op.a - op.b;
                overflow = (op.a[31] != op.b[31]) && (y[31] != op.a[31]);
            end
            `ALUOP_SUBU: y = op.a - op.b;
            `ALUOP_SLT:  y = word_t'($signed(op.a) < $signed(op.b));
            `ALUOP_SLTU: y = word_t'(op.a < op.b);
            `ALUOP_AND:  y = op.a & op.b;
            `ALUOP_OR:   y = op.a | op.b;
            `ALUOP_NOR:  y = ~(op.a | op.b);
            `ALUOP_XOR:  y = op.a ^ op.b;
            `ALUOP_LUI:  y = {op.b[15:0], 16'h0000};
            `ALUOP_SLL:  y = op.b << sh;
            `ALUOP_SRL:  y = op.b >> sh;
            `ALUOP_SRA:  y = $signed(op.b) >>> sh;
            `ALUOP_ROTR: y = rot[`ALU_WORD_W-1:0];
            `ALUOP_CLO:  y = lead_count(op.a, 1'b1);
            `ALUOP_CLZ:  y = lead_count(op.a, 1'b0);
            `ALUOP_MOV:  y = op.a;
            `ALUOP_MFHI: y = hilo[`ALU_DWORD_W-1:`ALU_WORD_W];
            `ALUOP_MFLO: y = hilo[`ALU_WORD_W-1:0];
            `ALUOP_MFC0: y = op.cp0_data;
            `ALUOP_MTHI: begin
                hilo_wr   = 1'b1;
                hilo_next = {op.a, hilo[`ALU_WORD_W-1:0]};
            end
            `ALUOP_MTLO: begin
                hilo_wr   = 1'b1;
                hilo_next = {hilo[`ALU_DWORD_W-1:`ALU_WORD_W], op.a};
            end
            default: y = '0;   // nop and multi-cycle ops
        endcase
    end

endmodule

// ==== src/mul_unit.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"

module mul_unit (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  logic            sign,
    input  alu_pkg::word_t  a,
    input  alu_pkg::word_t  b,
    output alu_pkg::dword_t result,
    output logic            ready
);
    import alu_pkg::*;

    localparam int CNT_W = $clog2(`MUL_LATENCY + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`MUL_LATENCY - 1);

    logic             busy;
    logic [CNT_W-1:0] count;
    logic             accept;
    word_t            mag_a;
    word_t            mag_b;
    logic             neg;
    dword_t           prod;

    assign accept = start && !busy;   // start while busy is ignored

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
            ready <= 1'b0;
        end else begin
            ready <= 1'b0;
            if (accept) begin
                busy  <= 1'b1;
                count <= CNT_W'(1);
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == LAST) begin
                    busy  <= 1'b0;
                    ready <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mag_a <= (sign && a[31]) ? -a : a;
            mag_b <= (sign && b[31]) ? -b : b;
            neg   <= sign && (a[31] ^ b[31]);
        end else if (busy) begin
            prod <= dword_t'(mag_a) * dword_t'(mag_b);
            if (count == LAST)
                result <= neg ? -prod : prod;   // sign fix on the way out
        end
    end

endmodule

// ==== src/div_unit.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"

module div_unit (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  logic            sign,
    input  alu_pkg::word_t  a,
    input  alu_pkg::word_t  b,
    output alu_pkg::dword_t result,
    output logic            ready
);
    import alu_pkg::*;

    localparam int CNT_W = $clog2(`DIV_ITER);

    div_state_t               state;
    logic [CNT_W-1:0]         step;
    word_t                    quo;       // dividend shifts out, quotient shifts in
    word_t                    rem;
    word_t                    dsr;
    word_t                    dividend;
    logic                     neg_q;
    logic                     neg_r;
    logic                     by_zero;
    logic [`ALU_WORD_W:0]     shifted;
    logic [`ALU_WORD_W:0]     diff;

    assign shifted = {rem, quo[`ALU_WORD_W-1]};
    assign diff    = shifted - {1'b0, dsr};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DIV_IDLE;
            step  <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        state <= DIV_BUSY;
                        step  <= '0;
                    end
                end
                DIV_BUSY: begin
                    step <= step + 1'b1;
                    if (step == CNT_W'(`DIV_ITER - 1))
                        state <= DIV_DONE;
                end
                default: state <= DIV_IDLE;   // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && start) begin
            quo      <= (sign && a[31]) ? -a : a;
            dsr      <= (sign && b[31]) ? -b : b;
            rem      <= '0;
            dividend <= a;
            neg_q    <= sign && (a[31] ^ b[31]);
            neg_r    <= sign && a[31];   // remainder follows the dividend
            by_zero  <= (b == '0);
        end else if (state == DIV_BUSY) begin
            if (!diff[`ALU_WORD_W]) begin   // restore skipped when no borrow
                rem <= diff[`ALU_WORD_W-1:0];
                quo <= {quo[`ALU_WORD_W-2:0], 1'b1};
            end else begin
                rem <= shifted[`ALU_WORD_W-1:0];
                quo <= {quo[`ALU_WORD_W-2:0], 1'b0};
            end
        end
    end

    assign ready = (state == DIV_DONE);

    always_comb begin
        if (by_zero)
            result = {dividend, {`ALU_WORD_W{1'b1}}};
        else
            result = {neg_r ? -rem : rem, neg_q ? -quo : quo};   // {hi, lo}
    end

endmodule

// ==== src/alu_master.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_master (
    input  logic                clk,
    input  logic                reset,
    input  alu_pkg::ex_op_t     op,
    input  alu_pkg::dword_t     hilo,
    output logic                stall,
    output alu_pkg::ex_result_t result
);
    import alu_pkg::*;

    ex_result_t simple_res;
    logic       mul_start;
    logic       mul_sign;
    dword_t     mul_result;
    logic       mul_ready;
    logic       div_start;
    logic       div_sign;
    dword_t     div_result;
    logic       div_ready;

    // last divide, kept for an identical follow-on
    logic       cache_valid;
    aluop_t     cache_op;
    word_t      cache_a;
    word_t      cache_b;
    dword_t     cache_result;
    logic       cache_hit;

    alu_simple u_simple (
        .op        (op),
        .hilo      (hilo),
        .y         (simple_res.y),
        .overflow  (simple_res.overflow),
        .hilo_wr   (simple_res.hilo_wr),
        .hilo_next (simple_res.hilo_next)
    );

    mul_unit u_mul (
        .clk    (clk),
        .reset  (reset),
        .start  (mul_start),
        .sign   (mul_sign),
        .a      (op.a),
        .b      (op.b),
        .result (mul_result),
        .ready  (mul_ready)
    );

    div_unit u_div (
        .clk    (clk),
        .reset  (reset),
        .start  (div_start),
        .sign   (div_sign),
        .a      (op.a),
        .b      (op.b),
        .result (div_result),
        .ready  (div_ready)
    );

    assign cache_hit = cache_valid && cache_op == op.aluop &&
                       cache_a == op.a && cache_b == op.b;

    always_comb begin
        mul_start = 1'b0;
        mul_sign  = 1'b0;
        div_start = 1'b0;
        div_sign  = 1'b0;
        stall     = 1'b0;
        result    = '0;
        case (op.aluop)
            `ALUOP_MULT, `ALUOP_MULTU, `ALUOP_MADD,
            `ALUOP_MSUB, `ALUOP_MADDU, `ALUOP_MSUBU: begin
                mul_sign = op.aluop == `ALUOP_MULT || op.aluop == `ALUOP_MADD ||
                           op.aluop == `ALUOP_MSUB;
                if (mul_ready) begin
                    result.hilo_wr = 1'b1;
                    case (op.aluop)
                        `ALUOP_MADD, `ALUOP_MADDU: result.hilo_next = hilo + mul_result;
                        `ALUOP_MSUB, `ALUOP_MSUBU: result.hilo_next = hilo - mul_result;
                        default: begin
                            result.hilo_next = mul_result;
                            result.y         = mul_result[`ALU_WORD_W-1:0];
                        end
                    endcase
                end else begin
                    mul_start = 1'b1;
                    stall     = 1'b1;
                end
            end
            `ALUOP_DIV, `ALUOP_DIVU: begin
                div_sign = (op.aluop == `ALUOP_DIV);
                if (div_ready) begin
                    result.hilo_wr   = 1'b1;
                    result.hilo_next = div_result;
                end else if (cache_hit) begin   // skip the divider
                    result.hilo_wr   = 1'b1;
                    result.hilo_next = cache_result;
                end else begin
                    div_start = 1'b1;
                    stall     = 1'b1;
                end
            end
            default: result = simple_res;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            cache_valid <= 1'b0;
        else if (div_ready)
            cache_valid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (div_ready) begin
            cache_op     <= op.aluop;
            cache_a      <= op.a;
            cache_b      <= op.b;
            cache_result <= div_result;
        end
    end

endmodule

// ==== src/ex_writeback.sv ====
`timescale 1ns/1ps

module ex_writeback (
    input  logic                clk,
    input  logic                reset,
    input  alu_pkg::ex_result_t result,
    output alu_pkg::word_t      y,
    output logic                overflow,
    output alu_pkg::dword_t     hilo
);
    import alu_pkg::*;

    word_t  y_q;
    logic   ovf_q;
    dword_t hilo_q;   // {hi, lo}

    always_ff @(posedge clk) begin
        if (reset) begin
            y_q    <= '0;
            ovf_q  <= 1'b0;
            hilo_q <= '0;
        end else begin
            y_q   <= result.y;
            ovf_q <= result.overflow;
            if (result.hilo_wr)
                hilo_q <= result.hilo_next;
        end
    end

    assign y        = y_q;
    assign overflow = ovf_q;
    assign hilo     = hilo_q;

endmodule

// ==== src/ex_top.sv ====
`timescale 1ns/1ps

module ex_top (
    input  logic            clk,
    input  logic            reset,
    input  alu_pkg::aluop_t aluop,
    input  alu_pkg::word_t  a,
    input  alu_pkg::word_t  b,
    input  alu_pkg::word_t  cp0_data,
    output logic            stall,
    output alu_pkg::word_t  y,
    output logic            overflow,
    output alu_pkg::dword_t hilo
);
    import alu_pkg::*;

    ex_op_t     op;
    ex_result_t ex_result;

    assign op = '{aluop: aluop, a: a, b: b, cp0_data: cp0_data};

    alu_master u_master (
        .clk    (clk),
        .reset  (reset),
        .op     (op),
        .hilo   (hilo),   // current hi/lo back from writeback
        .stall  (stall),
        .result (ex_result)
    );

    ex_writeback u_wb (
        .clk      (clk),
        .reset    (reset),
        .result   (ex_result),
        .y        (y),
        .overflow (overflow),
        .hilo     (hilo)
    );

endmodule

// ==== testbench/alu_model.svh ====
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// expected writeback values of one single-cycle op
function automatic ex_result_t single_cycle_ref(aluop_t op, word_t a, word_t b,
                                                word_t cp0, dword_t hilo);
    ex_result_t r;
    longint     wide;
    int         n;
    int         sh;
    logic       lead;
    r           = '0;
    r.hilo_next = hilo;
    sh          = int'(a[4:0]);
    lead        = (op == `ALUOP_CLO);
    n           = 0;
    case (op)
        `ALUOP_ADD, `ALUOP_SUB: begin
            if (op == `ALUOP_ADD)
                wide = longint'($signed(a)) + longint'($signed(b));
            else
                wide = longint'($signed(a)) - longint'($signed(b));
            r.y        = wide[31:0];
            r.overflow = wide != longint'($signed(wide[31:0]));   // does not fit 32 bits
        end
        `ALUOP_ADDU: r.y = a + b;
        `ALUOP_SUBU: r.y = a - b;
        `ALUOP_SLT:  r.y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        `ALUOP_SLTU: r.y = (a < b) ? 32'd1 : 32'd0;
        `ALUOP_AND:  r.y = a & b;
        `ALUOP_OR:   r.y = a | b;
        `ALUOP_NOR:  r.y = ~(a | b);
        `ALUOP_XOR:  r.y = a ^ b;
        `ALUOP_LUI:  r.y = b << 16;
        `ALUOP_SLL:  r.y = b << sh;
        `ALUOP_SRL:  r.y = b >> sh;
        `ALUOP_SRA: begin
            wide = longint'($signed(b)) >>> sh;
            r.y  = wide[31:0];
        end
        `ALUOP_ROTR: r.y = (b >> sh) | (b << (32 - sh));
        `ALUOP_CLO, `ALUOP_CLZ: begin
            while (n < 32 && a[31 - n] == lead)
                n++;
            r.y = word_t'(n);
        end
        `ALUOP_MOV:  r.y = a;
        `ALUOP_MFHI: r.y = hilo[63:32];
        `ALUOP_MFLO: r.y = hilo[31:0];
        `ALUOP_MFC0: r.y = cp0;
        `ALUOP_MTHI: begin
            r.hilo_wr   = 1'b1;
            r.hilo_next = {a, hilo[31:0]};
        end
        `ALUOP_MTLO: begin
            r.hilo_wr   = 1'b1;
            r.hilo_next = {hilo[63:32], a};
        end
        default: r.y = '0;
    endcase
    return r;
endfunction

// multiply and multiply-accumulate
function automatic ex_result_t mul_ref(aluop_t op, word_t a, word_t b, dword_t hilo);
    ex_result_t r;
    dword_t     prod;
    r = '0;
    if (op == `ALUOP_MULT || op == `ALUOP_MADD || op == `ALUOP_MSUB)
        prod = dword_t'(longint'($signed(a)) * longint'($signed(b)));
    else
        prod = {32'b0, a} * {32'b0, b};
    r.hilo_wr = 1'b1;
    case (op)
        `ALUOP_MADD, `ALUOP_MADDU: r.hilo_next = hilo + prod;
        `ALUOP_MSUB, `ALUOP_MSUBU: r.hilo_next = hilo - prod;
        default: begin
            r.hilo_next = prod;
            r.y         = prod[31:0];
        end
    endcase
    return r;
endfunction

// hi = remainder, lo = quotient, truncating
function automatic ex_result_t div_ref(aluop_t op, word_t a, word_t b);
    ex_result_t r;
    longint     q;
    longint     rm;
    r         = '0;
    r.hilo_wr = 1'b1;
    if (b == '0) begin
        r.hilo_next = {a, 32'hffff_ffff};
    end else if (op == `ALUOP_DIV) begin
        q           = longint'($signed(a)) / longint'($signed(b));
        rm          = longint'($signed(a)) % longint'($signed(b));
        r.hilo_next = {rm[31:0], q[31:0]};
    end else begin
        r.hilo_next = {a % b, a / b};
    end
    return r;
endfunction

`endif

// ==== testbench/tb_ex_top.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"

module tb_ex_top;
    import alu_pkg::*;

    localparam int N_SIMPLE   = 400;
    localparam int N_MUL      = 60;
    localparam int N_DIV      = 40;
    localparam int N_REPEAT   = 8;
    localparam int N_OPS      = 4 + N_SIMPLE + N_MUL + 3 + N_DIV + 3 * N_REPEAT;
    localparam int MAX_CYCLES = N_OPS * (`DIV_ITER + 3) + 200;

    logic   clk;
    logic   reset;
    aluop_t aluop;
    word_t  a;
    word_t  b;
    word_t  cp0_data;
    logic   stall;
    word_t  y;
    logic   overflow;
    dword_t hilo;

    logic [31:0] rng_state;
    dword_t      model_hilo;    // expected hi/lo
    logic        cache_valid;   // last divide that ran the divider
    aluop_t      cache_op;
    word_t       cache_a;
    word_t       cache_b;
    int          cycle_count = 0;

    `include "alu_model.svh"

    ex_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .aluop    (aluop),
        .a        (a),
        .b        (b),
        .cp0_data (cp0_data),
        .stall    (stall),
        .y        (y),
        .overflow (overflow),
        .hilo     (hilo)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // xorshift32
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // corner values show up often
    function automatic word_t pick_operand();
        logic [31:0] r;
        r = next_random();
        case (r[2:0])
            3'd0:    return '0;
            3'd1:    return '1;
            3'd2:    return 32'h8000_0000;
            3'd3:    return word_t'(r[7:3]);
            default: return next_random();
        endcase
    endfunction

    task automatic check_value(input string what, input dword_t expected,
                               input dword_t actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", what, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // present one op, hold it while stalled, check what writeback took
    task automatic run_op(input string test, input aluop_t op_v, input word_t a_v,
                          input word_t b_v);
        ex_result_t exp;
        int         exp_stall;
        int         stall_cycles;
        logic       is_div;
        word_t      cp0_v;
        string      what;
        cp0_v  = next_random();
        is_div = (op_v == `ALUOP_DIV || op_v == `ALUOP_DIVU);
        what   = $sformatf("%s op %02h", test, op_v);
        if (op_v >= `ALUOP_MULT && op_v <= `ALUOP_MSUBU) begin
            exp       = mul_ref(op_v, a_v, b_v, model_hilo);
            exp_stall = `MUL_LATENCY;
        end else if (is_div) begin
            exp = div_ref(op_v, a_v, b_v);
            if (cache_valid && cache_op == op_v && cache_a == a_v && cache_b == b_v)
                exp_stall = 0;
            else
                exp_stall = `DIV_ITER + 1;
        end else begin
            exp       = single_cycle_ref(op_v, a_v, b_v, cp0_v, model_hilo);
            exp_stall = 0;
        end
        aluop        = op_v;
        a            = a_v;
        b            = b_v;
        cp0_data     = cp0_v;
        stall_cycles = 0;
        #1;
        while (stall) begin
            stall_cycles++;
            @(negedge clk);
            #1;
        end
        @(negedge clk);   // result registered on the edge in between
        check_value($sformatf("%s stall cycles", what), dword_t'(exp_stall),
                    dword_t'(stall_cycles));
        check_value($sformatf("%s y", what), dword_t'(exp.y), dword_t'(y));
        check_value($sformatf("%s overflow", what), dword_t'(exp.overflow),
                    dword_t'(overflow));
        if (exp.hilo_wr)
            model_hilo = exp.hilo_next;
        check_value($sformatf("%s hilo", what), model_hilo, hilo);
        if (is_div && exp_stall != 0) begin
            cache_valid = 1'b1;
            cache_op    = op_v;
            cache_a     = a_v;
            cache_b     = b_v;
        end
    endtask

    initial begin
        aluop_t op_v;
        word_t  a_v;
        word_t  b_v;
        clk         = 1'b0;
        reset       = 1'b1;
        aluop       = `ALUOP_MTHI;   // would load hi/lo without a working reset
        a           = 32'h7fff_ffff;
        b           = 32'h0000_0001;
        cp0_data    = '0;
        rng_state   = 32'd44155;
        model_hilo  = '0;
        cache_valid = 1'b0;
        cache_op    = '0;
        cache_a     = '0;
        cache_b     = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        aluop = `ALUOP_ADD;   // overflowing add held off by reset
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_value("reset stall", '0, dword_t'(stall));
        check_value("reset y", '0, dword_t'(y));
        check_value("reset overflow", '0, dword_t'(overflow));
        check_value("reset hilo", '0, hilo);

        // moves into hi/lo read straight back
        run_op("move", `ALUOP_MTHI, pick_operand(), pick_operand());
        run_op("move", `ALUOP_MFHI, pick_operand(), pick_operand());
        run_op("move", `ALUOP_MTLO, pick_operand(), pick_operand());
        run_op("move", `ALUOP_MFLO, pick_operand(), pick_operand());

        for (int i = 0; i < N_SIMPLE; i++) begin
            op_v = aluop_t'(next_random() % 32'd24);
            run_op("simple", op_v, pick_operand(), pick_operand());
        end

        for (int i = 0; i < N_MUL; i++) begin
            op_v = aluop_t'(`ALUOP_MULT + next_random() % 32'd6);
            run_op("mul", op_v, pick_operand(), pick_operand());
        end

        run_op("div zero", `ALUOP_DIV, pick_operand(), '0);
        run_op("div zero", `ALUOP_DIVU, 32'h1234_5678, '0);
        run_op("div min", `ALUOP_DIV, 32'h8000_0000, 32'hffff_ffff);
        for (int i = 0; i < N_DIV; i++) begin
            op_v = aluop_t'(`ALUOP_DIV + next_random() % 32'd2);
            run_op("div", op_v, pick_operand(), pick_operand());
        end

        // same divide again hits the cache, a new one runs in full
        for (int i = 0; i < N_REPEAT; i++) begin
            op_v = aluop_t'(`ALUOP_DIV + next_random() % 32'd2);
            a_v  = pick_operand();
            b_v  = pick_operand();
            run_op("div first", op_v, a_v, b_v);
            run_op("div cached", op_v, a_v, b_v);
            run_op("div changed", op_v, a_v, b_v + 1'b1);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== alu_ex.f ====
+incdir+src
+incdir+testbench
src/alu_pkg.sv
src/alu_simple.sv
src/mul_unit.sv
src/div_unit.sv
src/alu_master.sv
src/ex_writeback.sv
src/ex_top.sv
testbench/tb_ex_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute-stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ex_top -f alu_ex.f -o sim_ex_top

./obj_dir/sim_ex_top | tee sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
